//--- fp_add_unit.f
fp_pkg.sv
fp_operands_if.sv
fp_sum_if.sv
fp_unpack.sv
fp_align_add.sv
fp_norm_round.sv
fp_add_unit.sv
fp_add_unit_tb.sv

//--- fp_add_unit.sv
/*
 * single precision fp add unit: unpack, align/add and normalize/round
 * stages joined by two handshake interfaces
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_stb,
  input  fp_pkg::fp_word_t in_a,
  input  fp_pkg::fp_word_t in_b,
  output fp_pkg::fp_word_t result,
  output logic             result_stb,
  output logic             busy
);

  fp_operands_if ops_if ();
  fp_sum_if      sums_if ();

  fp_unpack unpack_i (
    .clk        (clk),
    .rst        (rst),
    .in_stb     (in_stb),
    .in_a       (in_a),
    .in_b       (in_b),
    .result_stb (result_stb),
    .busy       (busy),
    .ops        (ops_if.src)
  );

  fp_align_add align_add_i (
    .clk  (clk),
    .rst  (rst),
    .ops  (ops_if.dst),
    .sums (sums_if.src)
  );

  // result_stb also releases busy in the unpack stage
  fp_norm_round norm_round_i (
    .clk        (clk),
    .rst        (rst),
    .sums       (sums_if.dst),
    .result     (result),
    .result_stb (result_stb)
  );

endmodule

`default_nettype wire

//--- fp_add_unit_tb.sv
/*
 * testbench for the fp add unit that runs the operations from the vector file
 * and checks the handshake around strobes that arrive while busy
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_unit_tb;
  import fp_pkg::*;

  localparam int busy_timeout   = 200;
  localparam int result_timeout = 200;

  logic     clk;
  logic     rst;
  logic     in_stb;
  fp_word_t in_a;
  fp_word_t in_b;
  fp_word_t result;
  logic     result_stb;
  logic     busy;
  integer   seed;
  integer   fd;

  fp_add_unit dut_i (
    .clk        (clk),
    .rst        (rst),
    .in_stb     (in_stb),
    .in_a       (in_a),
    .in_b       (in_b),
    .result     (result),
    .result_stb (result_stb),
    .busy       (busy)
  );

  always #5 clk = ~clk;

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_result(input fp_word_t got, input fp_word_t expected,
                              input fp_word_t a, input fp_word_t b);
    if (got !== expected) begin
      stop_with_fail($sformatf("ERROR: result = %h, expected %h (a = %h, b = %h)",
                               got, expected, a, b));
    end
  endtask

  task automatic check_busy(input logic got, input logic expected);
    if (got !== expected) begin
      stop_with_fail($sformatf("ERROR: busy = %h, expected %h", got, expected));
    end
  endtask

  // returns at a falling edge with busy low
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      n++;
      if (n > busy_timeout) begin
        stop_with_fail("busy did not go low within the timeout");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_result(output fp_word_t got);
    int n;
    n = 0;
    @(negedge clk);
    while (result_stb !== 1'b1) begin
      n++;
      if (n > result_timeout) begin
        stop_with_fail("no result arrived within the timeout");
      end
      @(negedge clk);
    end
    got = result;
  endtask

  task automatic run_op(input fp_word_t a, input fp_word_t b, input fp_word_t expected);
    fp_word_t got;
    wait_idle();
    @(posedge clk);
    in_stb <= 1'b1;
    in_a   <= a;
    in_b   <= b;
    @(posedge clk);
    in_stb <= 1'b0;
    @(negedge clk);
    check_busy(busy, 1'b1);
    wait_result(got);
    check_result(got, expected, a, b);
  endtask

  // the strobe stays high with other operands until the result arrives
  // so every strobe after the first one meets busy high
  task automatic run_dropped_strobe();
    fp_word_t got;
    int       extra;
    extra = 0;
    wait_idle();
    @(posedge clk);
    in_stb <= 1'b1;
    in_a   <= 32'h3f80_0000;
    in_b   <= 32'h4000_0000;
    @(posedge clk);
    in_b   <= 32'h4040_0000;
    @(negedge clk);
    check_busy(busy, 1'b1);
    wait_result(got);
    @(posedge clk);
    in_stb <= 1'b0;
    check_result(got, 32'h4040_0000, 32'h3f80_0000, 32'h4000_0000);
    @(negedge clk);
    check_busy(busy, 1'b0);
    repeat (50) begin
      @(negedge clk);
      if (result_stb === 1'b1) begin
        extra++;
      end
    end
    if (extra != 0) begin
      stop_with_fail("a strobe sent while busy produced a second result");
    end
  endtask

  initial begin
    fp_word_t a;
    fp_word_t b;
    fp_word_t expected;
    string    line;
    int       n_ops;
    int       idle;
    seed   = 32'hd2e4_ca2b;
    clk    = 1'b0;
    rst    = 1'b1;
    in_stb = 1'b0;
    in_a   = '0;
    in_b   = '0;
    n_ops  = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_busy(busy, 1'b0);
    run_dropped_strobe();

    fd = $fopen("fp_add_vectors.txt", "r");
    if (fd == 0) begin
      stop_with_fail("could not open fp_add_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // comment and blank lines do not parse as three hex words
      if ($sscanf(line, "%h %h %h", a, b, expected) != 3) begin
        continue;
      end
      idle = $unsigned($random(seed)) % 4;
      repeat (idle) @(negedge clk);
      run_op(a, b, expected);
      n_ops++;
    end
    $fclose(fd);

    if (n_ops == 0) begin
      stop_with_fail("the vector file held no operations");
    end else begin
      $display("%0d operations checked", n_ops);
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- fp_add_vectors.txt
# columns: operand_a operand_b expected_sum, IEEE single words in hex
# expected sums use round to nearest even, any NaN input gives ffc00000
3f800000 3f800000 40000000
40400000 bf800000 40000000
3f800000 bf000000 3f000000
c1200000 40a00000 c0a00000
3f800000 33800000 3f800000
3f800001 33800000 3f800002
3f800000 33800001 3f800001
3fffffff 3f800000 40400000
3f800000 b3800000 3f7fffff
3f800000 b3000000 3f800000
4d800000 3f800000 4d800000
3f800000 af800000 3f800000
3f800000 00000001 3f800000
3f800000 bf800000 00000000
00000005 80000005 00000000
00000000 40400000 40400000
80000000 80000000 80000000
80000000 80000003 80000003
00000001 00000001 00000002
00400000 00400000 00800000
807fffff 80000001 80800000
00800001 80800000 00000001
01000000 80c00000 00400000
00800000 80000001 007fffff
7f7fffff 7f7fffff 7f800000
7f7fffff 73000000 7f800000
7f7fffff 72800000 7f7fffff
7fc00000 3f800000 ffc00000
3f800000 7f800001 ffc00000
7f800000 3f800000 7f800000
7f800000 ff800000 ffc00000
ff800000 7f800000 7fc00000

//--- fp_align_add.sv
/*
 * fp add align stage: shifts the smaller operand one place per cycle
 * with sticky collection, then adds or subtracts the mantissas
 */
`timescale 1ns/1ps
`default_nettype none

module fp_align_add (
  input  logic       clk,
  input  logic       rst,
  fp_operands_if.dst ops,
  fp_sum_if.src      sums
);
  import fp_pkg::*;

  // past this many places the shifted mantissa is only its sticky bit
  localparam int max_steps = $bits(fp_mant_t);

  align_state_t state;
  logic         a_sign, b_sign;
  fp_mant_t     a_mant, b_mant;
  fp_exp_t      z_exp;
  logic         shift_b;
  logic [4:0]   steps;
  fp_exp_t      exp_diff;
  fp_exp_t      diff_abs;

  function automatic fp_mant_t sticky_shr(fp_mant_t m);
    return (m >> 1) | fp_mant_t'(m[0]);
  endfunction

  assign exp_diff = ops.a_exp - ops.b_exp;
  assign diff_abs = (exp_diff < 0) ? -exp_diff : exp_diff;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= align_idle;
      sums.stb <= 1'b0;
    end else begin
      sums.stb <= 1'b0;
      case (state)
        align_idle: begin
          if (ops.stb && ops.special) begin
            sums.special      <= 1'b1;
            sums.special_word <= ops.special_word;
            sums.stb          <= 1'b1;
          end else if (ops.stb) begin
            state <= (exp_diff == '0) ? align_add : align_shift;
          end
        end
        align_shift: begin
          if (shift_b) begin
            b_mant <= sticky_shr(b_mant);
          end else begin
            a_mant <= sticky_shr(a_mant);
          end
          steps <= steps - 5'd1;
          if (steps == 5'd1) begin
            state <= align_add;
          end
        end
        align_add: begin
          sums.special <= 1'b0;
          sums.exp     <= z_exp;
          if (a_sign == b_sign) begin
            sums.sum  <= {1'b0, a_mant} + {1'b0, b_mant};
            sums.sign <= a_sign;
          end else if (a_mant >= b_mant) begin
            sums.sum  <= {1'b0, a_mant - b_mant};
            sums.sign <= a_sign;
          end else begin
            sums.sum  <= {1'b0, b_mant - a_mant};
            sums.sign <= b_sign;
          end
          sums.stb <= 1'b1;
          state    <= align_idle;
        end
        default: state <= align_idle;
      endcase
    end

    // operand capture, the larger exponent becomes the result exponent
    if (state == align_idle && ops.stb) begin
      a_sign  <= ops.a_sign;
      b_sign  <= ops.b_sign;
      a_mant  <= ops.a_mant;
      b_mant  <= ops.b_mant;
      shift_b <= exp_diff > 0;
      z_exp   <= (exp_diff > 0) ? ops.a_exp : ops.b_exp;
      steps   <= (diff_abs > max_steps) ? 5'(max_steps) : diff_abs[4:0];
    end
  end

endmodule

`default_nettype wire

//--- fp_norm_round.sv
/*
 * fp add normalize stage: normalizes the raw sum, handles denormal results,
 * rounds to nearest even and packs the result word
 */
`timescale 1ns/1ps
`default_nettype none

module fp_norm_round (
  input  logic              clk,
  input  logic              rst,
  fp_sum_if.dst             sums,
  output fp_pkg::fp_word_t  result,
  output logic              result_stb
);
  import fp_pkg::*;

  norm_state_t state;
  logic        z_sign;
  fp_exp_t     z_exp;
  fp_sum_t     sum_r;
  logic        special_r;
  fp_word_t    special_word_r;
  fp_frac_t    z_mant;
  logic        guard, round_bit, sticky;

  fp_frac_t    split_mant;
  fp_exp_t     split_exp;
  logic        split_guard, split_round, split_sticky;

  // carry out moves everything down one place
  always_comb begin
    if (sum_r[27]) begin
      split_mant   = sum_r[27:4];
      split_guard  = sum_r[3];
      split_round  = sum_r[2];
      split_sticky = |sum_r[1:0];
      split_exp    = z_exp + 10'sd1;
    end else begin
      split_mant   = sum_r[26:3];
      split_guard  = sum_r[2];
      split_round  = sum_r[1];
      split_sticky = sum_r[0];
      split_exp    = z_exp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= norm_idle;
      result_stb <= 1'b0;
    end else begin
      result_stb <= 1'b0;
      case (state)
        norm_idle: begin
          if (sums.stb) begin
            z_sign         <= sums.sign;
            z_exp          <= sums.exp;
            sum_r          <= sums.sum;
            special_r      <= sums.special;
            special_word_r <= sums.special_word;
            state          <= sums.special ? norm_pack : norm_split;
          end
        end
        norm_split: begin
          if (sum_r == '0) begin
            // exact zero, nothing to normalize
            z_mant    <= '0;
            guard     <= 1'b0;
            round_bit <= 1'b0;
            sticky    <= 1'b0;
            z_exp     <= exp_min;
            state     <= norm_round;
          end else begin
            z_mant    <= split_mant;
            guard     <= split_guard;
            round_bit <= split_round;
            sticky    <= split_sticky;
            z_exp     <= split_exp;
            if (!split_mant[23] && split_exp > exp_min) begin
              state <= norm_left;
            end else if (split_exp < exp_min) begin
              state <= norm_right;
            end else begin
              state <= norm_round;
            end
          end
        end
        norm_left: begin
          z_mant    <= {z_mant[22:0], guard};
          guard     <= round_bit;
          round_bit <= 1'b0;
          z_exp     <= z_exp - 10'sd1;
          if (z_mant[22] || z_exp == exp_min + 10'sd1) begin
            state <= norm_round;
          end
        end
        norm_right: begin
          z_mant    <= z_mant >> 1;
          guard     <= z_mant[0];
          round_bit <= guard;
          sticky    <= sticky | round_bit;
          z_exp     <= z_exp + 10'sd1;
          if (z_exp == exp_min - 10'sd1) begin
            state <= norm_round;
          end
        end
        norm_round: begin
          if (guard && (round_bit || sticky || z_mant[0])) begin
            z_mant <= z_mant + 24'd1;
            if (z_mant == '1) begin
              z_exp <= z_exp + 10'sd1;
            end
          end
          state <= norm_pack;
        end
        norm_pack: begin
          if (special_r) begin
            result <= special_word_r;
          end else if (z_exp >= exp_max) begin
            result <= {z_sign, 8'hff, 23'b0};
          end else if (z_exp == exp_min && z_mant == '0) begin
            result <= '0;
          end else if (z_exp == exp_min && !z_mant[23]) begin
            result <= {z_sign, 8'h00, z_mant[22:0]};
          end else begin
            result <= {z_sign, 8'(z_exp + exp_bias), z_mant[22:0]};
          end
          result_stb <= 1'b1;
          state      <= norm_idle;
        end
        default: state <= norm_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- fp_operands_if.sv
/*
 * unpacked operands, or a resolved special result, from unpack to align
 */
`timescale 1ns/1ps
`default_nettype none

interface fp_operands_if;
  import fp_pkg::*;

  logic     stb;
  logic     a_sign;
  fp_exp_t  a_exp;
  fp_mant_t a_mant;
  logic     b_sign;
  fp_exp_t  b_exp;
  fp_mant_t b_mant;
  // special set means special_word is the final answer
  logic     special;
  fp_word_t special_word;

  modport src (
    output stb, a_sign, a_exp, a_mant, b_sign, b_exp, b_mant,
    output special, special_word
  );

  modport dst (
    input stb, a_sign, a_exp, a_mant, b_sign, b_exp, b_mant,
    input special, special_word
  );

endinterface

`default_nettype wire

//--- fp_pkg.sv
/*
 * fp add package: single precision word, exponent and mantissa types,
 * format constants and the stage state encodings
 */
`default_nettype none

package fp_pkg;

  typedef logic [31:0] fp_word_t;

  // unbiased, wide enough to pass 127 before the overflow check
  typedef logic signed [9:0] fp_exp_t;

  // hidden bit on top, guard/round/sticky positions below
  typedef logic [26:0] fp_mant_t;
  typedef logic [27:0] fp_sum_t;
  typedef logic [23:0] fp_frac_t;

  localparam fp_exp_t exp_bias = 10'sd127;
  localparam fp_exp_t exp_max = 10'sd128;
  localparam fp_exp_t exp_min = -10'sd126;

  localparam fp_word_t qnan_word = 32'hffc0_0000;

  typedef enum logic [1:0] {
    align_idle,
    align_shift,
    align_add
  } align_state_t;

  typedef enum logic [2:0] {
    norm_idle,
    norm_split,
    norm_left,
    norm_right,
    norm_round,
    norm_pack
  } norm_state_t;

endpackage

`default_nettype wire

//--- fp_sum_if.sv
/*
 * raw aligned sum, or a special result passed through, from align to normalize
 */
`timescale 1ns/1ps
`default_nettype none

interface fp_sum_if;
  import fp_pkg::*;

  logic     stb;
  logic     sign;
  fp_exp_t  exp;
  // bit 27 is the carry out of the mantissa add
  fp_sum_t  sum;
  logic     special;
  fp_word_t special_word;

  modport src (
    output stb, sign, exp, sum, special, special_word
  );

  modport dst (
    input stb, sign, exp, sum, special, special_word
  );

endinterface

`default_nettype wire

//--- fp_unpack.sv
/*
 * fp add unpack stage: accepts the operands, holds busy, resolves
 * NaN/infinity/zero cases and restores hidden bits
 */
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_stb,
  input  fp_pkg::fp_word_t in_a,
  input  fp_pkg::fp_word_t in_b,
  input  logic             result_stb,
  output logic             busy,
  fp_operands_if.src       ops
);
  import fp_pkg::*;

  logic     accept;
  fp_exp_t  a_field_exp;
  fp_exp_t  b_field_exp;
  logic     a_nan, b_nan;
  logic     a_inf, b_inf;
  logic     a_zero, b_zero;
  logic     special;
  fp_word_t special_word;

  function automatic fp_exp_t field_exp(fp_word_t w);
    return fp_exp_t'({2'b00, w[30:23]}) - exp_bias;
  endfunction

  // denormals sit at the smallest normal exponent without a hidden bit
  function automatic fp_exp_t operand_exp(fp_word_t w);
    return (w[30:23] == 8'h00) ? exp_min : field_exp(w);
  endfunction

  function automatic fp_mant_t operand_mant(fp_word_t w);
    return {w[30:23] != 8'h00, w[22:0], 3'b000};
  endfunction

  assign accept = in_stb && !busy;

  assign a_field_exp = field_exp(in_a);
  assign b_field_exp = field_exp(in_b);

  assign a_nan  = (a_field_exp == exp_max) && (in_a[22:0] != '0);
  assign b_nan  = (b_field_exp == exp_max) && (in_b[22:0] != '0);
  assign a_inf  = (a_field_exp == exp_max) && (in_a[22:0] == '0);
  assign b_inf  = (b_field_exp == exp_max) && (in_b[22:0] == '0);
  assign a_zero = (in_a[30:0] == '0);
  assign b_zero = (in_b[30:0] == '0);

  always_comb begin
    special      = 1'b1;
    special_word = '0;
    if (a_nan || b_nan) begin
      special_word = qnan_word;
    end else if (a_inf && b_inf && (in_a[31] != in_b[31])) begin
      // inf - inf, quiet NaN carries b's sign
      special_word = {in_b[31], qnan_word[30:0]};
    end else if (a_inf) begin
      special_word = in_a;
    end else if (b_inf) begin
      special_word = in_b;
    end else if (a_zero && b_zero) begin
      special_word = {in_a[31] & in_b[31], 31'b0};
    end else if (a_zero) begin
      special_word = in_b;
    end else if (b_zero) begin
      special_word = in_a;
    end else begin
      special = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      ops.stb <= 1'b0;
    end else begin
      ops.stb <= accept;
      if (result_stb) begin
        busy <= 1'b0;
      end else if (accept) begin
        busy <= 1'b1;
      end
    end

    if (accept) begin
      ops.a_sign       <= in_a[31];
      ops.a_exp        <= operand_exp(in_a);
      ops.a_mant       <= operand_mant(in_a);
      ops.b_sign       <= in_b[31];
      ops.b_exp        <= operand_exp(in_b);
      ops.b_mant       <= operand_mant(in_b);
      ops.special      <= special;
      ops.special_word <= special_word;
    end
  end

endmodule

`default_nettype wire
